// ==== hdl/io_bridge.sv ====
module io_bridge (
	input  logic             clk_sys,
	input  logic             reset_cpu,
	input  logic             cpu_req,
	input  logic             cpu_write,
	input  io_pkg::io_addr_t cpu_address,
	input  io_pkg::io_len_t  cpu_length,
	input  io_pkg::io_data_t cpu_writedata,
	output logic             cpu_ack,
	output io_pkg::io_data_t cpu_readdata,
	input  logic             io32,
	input  io_pkg::io_data_t bus_readdata,
	output io_pkg::io_addr_t bus_address,
	output io_pkg::io_len_t  bus_datasize,
	output io_pkg::io_data_t bus_writedata,
	output logic             bus_read,
	output logic             bus_write
);
	import io_pkg::*;

	typedef enum logic [2:0] {IDLE, SETUP, SETTLE, STROBE, DONE, RELEASE} state_t;

	state_t     state;
	logic       req_write;
	io_len_t    req_len;
	io_data_t   req_wdata;
	logic [1:0] beat;
	logic       wide;
	logic       wide_now;
	logic       last_beat;
	io_data_t   len_mask;
	io_data_t   assembly;

	assign wide_now  = (beat == 2'd0) ? io32 : wide; // First beat decides.
	assign last_beat = wide || (beat == 2'(req_len - 3'd1));

	always_comb begin
		for (int k = 0; k < 4; k++)
			len_mask[8*k +: 8] = (k < int'(req_len)) ? 8'hFF : 8'h00;
	end

	always_ff @(posedge clk_sys) begin
		if (reset_cpu) begin
			state       <= IDLE;
			cpu_ack     <= 1'b0;
			bus_read    <= 1'b0;
			bus_write   <= 1'b0;
			beat        <= 2'd0;
			wide        <= 1'b0;
			bus_address <= '1; // Unmapped port.
		end else begin
			bus_read  <= 1'b0;
			bus_write <= 1'b0;
			case (state)
				IDLE: if (cpu_req) begin
					bus_address <= cpu_address;
					beat        <= 2'd0;
					state       <= SETUP;
				end
				SETUP: state <= SETTLE;
				SETTLE: begin
					if (beat == 2'd0)
						wide <= io32;
					bus_read  <= !req_write;
					bus_write <= req_write;
					state     <= STROBE;
				end
				STROBE: if (last_beat) begin
					state <= DONE;
				end else begin
					beat        <= beat + 2'd1;
					bus_address <= bus_address + 1'b1; // Next byte port.
					state       <= SETUP;
				end
				DONE: begin
					cpu_ack <= 1'b1;
					state   <= RELEASE;
				end
				RELEASE: if (!cpu_req) begin
					cpu_ack <= 1'b0;
					state   <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		case (state)
			IDLE: if (cpu_req) begin
				req_write <= cpu_write;
				req_len   <= cpu_length;
				req_wdata <= cpu_writedata;
				assembly  <= '0;
			end
			SETTLE: begin
				bus_datasize  <= wide_now ? req_len : 3'd1;
				bus_writedata <= wide_now ? req_wdata : io_data_t'(req_wdata[8*beat +: 8]);
			end
			STROBE: if (!req_write) begin
				if (wide)
					assembly <= bus_readdata & len_mask;
				else
					assembly[8*beat +: 8] <= bus_readdata[7:0];
			end
			DONE: cpu_readdata <= assembly;
			default: ;
		endcase
	end

endmodule

// ==== hdl/io_decode.sv ====
`include "io_settings.svh"

module io_decode (
	input  logic               clk_sys,
	input  logic               reset_cpu,
	input  io_pkg::io_addr_t   bus_address,
	input  io_pkg::io_data_t   hdd0_readdata,
	input  io_pkg::io_data_t   hdd1_readdata,
	input  io_pkg::byte_bank_t byte_readdata,
	output io_pkg::io_dev_t    dev_sel,
	output logic               io32,
	output io_pkg::io_data_t   bus_readdata
);
	import io_pkg::*;

	io_dev_t    dev_next;
	logic       io32_next;
	logic [3:0] byte_idx;

	// Address lies in the aligned block of 2**span ports at base.
	function automatic logic hit(input io_addr_t addr, input io_addr_t base,
			input int unsigned span);
		return (addr >> span) == (base >> span);
	endfunction

	// Order matters where ranges overlap (3F6, 061).
	always_comb begin
		dev_next = DEV_NONE;
		if (hit(bus_address, `HDD0_BASE, 3) || bus_address == `HDD0_CTL)
			dev_next = DEV_HDD0;
		else if (hit(bus_address, `HDD1_BASE, 3) || bus_address == `HDD1_CTL)
			dev_next = DEV_HDD1;
		else if (hit(bus_address, `FLOPPY_BASE, 3))
			dev_next = DEV_FLOPPY;
		else if (hit(bus_address, `DMA_MASTER_BASE, 5) || hit(bus_address, `DMA_PAGE_BASE, 4) ||
				hit(bus_address, `DMA_SLAVE_BASE, 4))
			dev_next = DEV_DMA;
		else if (hit(bus_address, `PIC_MASTER_BASE, 1) || hit(bus_address, `PIC_SLAVE_BASE, 1))
			dev_next = DEV_PIC;
		else if (hit(bus_address, `PIT_BASE, 2) || bus_address == `PIT_SPEAKER)
			dev_next = DEV_PIT;
		else if (hit(bus_address, `PS2_IO_BASE, 3) || hit(bus_address, `PS2_CTL_BASE, 4))
			dev_next = DEV_PS2;
		else if (hit(bus_address, `RTC_BASE, 1))
			dev_next = DEV_RTC;
		else if (hit(bus_address, `SB_BASE, 4) || hit(bus_address, `FM_BASE, 2))
			dev_next = DEV_SOUND;
		else if (hit(bus_address, `UART_BASE, 3) || hit(bus_address, `MPU_BASE, 1))
			dev_next = DEV_UART;
		else if (hit(bus_address, `VGA_B_BASE, 4) || hit(bus_address, `VGA_C_BASE, 4) ||
				hit(bus_address, `VGA_D_BASE, 4))
			dev_next = DEV_VGA;
		else if (bus_address == `JOY_PORT)
			dev_next = DEV_JOY;
		else if (bus_address == `SYSCTL_PORT)
			dev_next = DEV_SYSCTL;
	end

	// Disk data ports take 16/32-bit accesses in one go. Control ports do not.
	assign io32_next = ((dev_next == DEV_HDD0 || dev_next == DEV_HDD1) && !bus_address[9]) ||
		dev_next == DEV_SYSCTL;

	always_ff @(posedge clk_sys) begin
		if (reset_cpu) begin
			dev_sel <= DEV_NONE;
			io32    <= 1'b0;
		end else begin
			dev_sel <= dev_next;
			io32    <= io32_next;
		end
	end

	always_comb begin
		byte_idx = 4'(dev_sel) - 4'(DEV_FLOPPY);
		case (dev_sel)
			DEV_HDD0:             bus_readdata = hdd0_readdata;
			DEV_HDD1:             bus_readdata = hdd1_readdata;
			DEV_NONE, DEV_SYSCTL: bus_readdata = '1; // Open bus.
			default:              bus_readdata = io_data_t'(byte_readdata[byte_idx]);
		endcase
	end

endmodule

// ==== hdl/io_pkg.sv ====
`include "io_settings.svh"

package io_pkg;

	typedef logic [`IO_ADDR_W-1:0] io_addr_t;
	typedef logic [`IO_DATA_W-1:0] io_data_t;
	typedef logic [2:0]            io_len_t; // Bytes per access.

	typedef enum logic [3:0] {
		DEV_NONE,
		DEV_HDD0,
		DEV_HDD1,
		DEV_FLOPPY,
		DEV_DMA,
		DEV_PIC,
		DEV_PIT,
		DEV_PS2,
		DEV_RTC,
		DEV_SOUND,
		DEV_UART,
		DEV_VGA,
		DEV_JOY,
		DEV_SYSCTL
	} io_dev_t;

	// Byte-wide devices sit between floppy and joystick in the enum.
	localparam int BYTE_DEVS = int'(DEV_JOY) - int'(DEV_FLOPPY) + 1;

	typedef logic [BYTE_DEVS-1:0][7:0] byte_bank_t; // Entry 0 is floppy.

endpackage

// ==== hdl/io_settings.svh ====
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

`define IO_ADDR_W       16
`define IO_DATA_W       32

`define SYSCTL_KEY      8'hA1
`define SYSCTL_RESET    8'hA2

`define HDD0_BASE       16'h01F0
`define HDD0_CTL        16'h03F6
`define HDD1_BASE       16'h0170
`define HDD1_CTL        16'h0376
`define FLOPPY_BASE     16'h03F0
`define DMA_MASTER_BASE 16'h00C0
`define DMA_PAGE_BASE   16'h0080
`define DMA_SLAVE_BASE  16'h0000
`define PIC_MASTER_BASE 16'h0020
`define PIC_SLAVE_BASE  16'h00A0
`define PIT_BASE        16'h0040
`define PIT_SPEAKER     16'h0061
`define PS2_IO_BASE     16'h0060
`define PS2_CTL_BASE    16'h0090
`define RTC_BASE        16'h0070
`define SB_BASE         16'h0220
`define FM_BASE         16'h0388
`define UART_BASE       16'h03F8
`define MPU_BASE        16'h0330
`define VGA_B_BASE      16'h03B0
`define VGA_C_BASE      16'h03C0
`define VGA_D_BASE      16'h03D0
`define JOY_PORT        16'h0201
`define SYSCTL_PORT     16'h8888

`endif

// ==== hdl/io_system.sv ====
module io_system (
	input  logic               clk_sys,
	input  logic               reset_cpu,
	input  logic               cpu_req,
	input  logic               cpu_write,
	input  io_pkg::io_addr_t   cpu_address,
	input  io_pkg::io_len_t    cpu_length,
	input  io_pkg::io_data_t   cpu_writedata,
	output logic               cpu_ack,
	output io_pkg::io_data_t   cpu_readdata,
	output io_pkg::io_addr_t   bus_address,
	output io_pkg::io_len_t    bus_datasize,
	output io_pkg::io_data_t   bus_writedata,
	output logic               bus_read,
	output logic               bus_write,
	output io_pkg::io_dev_t    dev_sel,
	input  io_pkg::io_data_t   hdd0_readdata,
	input  io_pkg::io_data_t   hdd1_readdata,
	input  io_pkg::byte_bank_t byte_readdata,
	output logic [7:0]         syscfg
);
	import io_pkg::*;

	logic     io32;
	io_data_t bus_readdata;

	io_bridge bridge0 (
		.clk_sys       (clk_sys),
		.reset_cpu     (reset_cpu),
		.cpu_req       (cpu_req),
		.cpu_write     (cpu_write),
		.cpu_address   (cpu_address),
		.cpu_length    (cpu_length),
		.cpu_writedata (cpu_writedata),
		.cpu_ack       (cpu_ack),
		.cpu_readdata  (cpu_readdata),
		.io32          (io32),
		.bus_readdata  (bus_readdata),
		.bus_address   (bus_address),
		.bus_datasize  (bus_datasize),
		.bus_writedata (bus_writedata),
		.bus_read      (bus_read),
		.bus_write     (bus_write)
	);

	io_decode decode0 (
		.clk_sys       (clk_sys),
		.reset_cpu     (reset_cpu),
		.bus_address   (bus_address),
		.hdd0_readdata (hdd0_readdata),
		.hdd1_readdata (hdd1_readdata),
		.byte_readdata (byte_readdata),
		.dev_sel       (dev_sel),
		.io32          (io32),
		.bus_readdata  (bus_readdata)
	);

	// Watches the decoded device as well as writes.
	sysctl_port sysctl0 (
		.clk_sys       (clk_sys),
		.reset_cpu     (reset_cpu),
		.dev_sel       (dev_sel),
		.bus_write     (bus_write),
		.bus_datasize  (bus_datasize),
		.bus_writedata (bus_writedata),
		.syscfg        (syscfg)
	);

endmodule

// ==== hdl/sysctl_port.sv ====
`include "io_settings.svh"

module sysctl_port (
	input  logic             clk_sys,
	input  logic             reset_cpu,
	input  io_pkg::io_dev_t  dev_sel,
	input  logic             bus_write,
	input  io_pkg::io_len_t  bus_datasize,
	input  io_pkg::io_data_t bus_writedata,
	output logic [7:0]       syscfg
);
	import io_pkg::*;

	logic in_reset;
	logic disk_sel;
	logic key_write;

	assign disk_sel = dev_sel == DEV_HDD0 || dev_sel == DEV_HDD1 || dev_sel == DEV_FLOPPY;

	// Only a keyed 16-bit write reaches the register.
	assign key_write = bus_write && dev_sel == DEV_SYSCTL && bus_datasize == 3'd2 &&
		bus_writedata[15:8] == `SYSCTL_KEY;

	always_ff @(posedge clk_sys) begin
		if (reset_cpu) begin
			syscfg   <= `SYSCTL_RESET;
			in_reset <= 1'b1;
		end else if (disk_sel && in_reset) begin
			syscfg   <= 8'h00; // Boot has reached the disks.
			in_reset <= 1'b0;
		end else if (key_write) begin
			syscfg   <= bus_writedata[7:0];
			in_reset <= 1'b0;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_io_system -f verilog.f 2>&1 \
	&& ./obj_dir/Vtb_io_system 2>&1) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1

// ==== sim/tb_io_system.sv ====
module tb_io_system;
	timeunit 1ns;
	timeprecision 100ps;
	import io_pkg::*;

	localparam int N_SYSCTL = 6;
	localparam int N_READS  = 120;
	localparam int N_SPLIT  = 40;
	localparam int TIMEOUT  = (2 + N_SYSCTL + N_READS + N_SPLIT) * 20 + 100;
	localparam io_addr_t REGION [16] = '{16'h01F0, 16'h03F6, 16'h0170, 16'h0376, 16'h03F0,
		16'h00C0, 16'h0000, 16'h0020, 16'h005C, 16'h0070, 16'h0220, 16'h0388, 16'h03F8,
		16'h03B0, 16'h01FC, 16'h8886};

	logic       clk_sys, reset_cpu, cpu_req, cpu_write, cpu_ack, bus_read, bus_write;
	io_addr_t   cpu_address, bus_address;
	io_len_t    cpu_length, bus_datasize;
	io_data_t   cpu_writedata, cpu_readdata, bus_writedata, hdd0_readdata, hdd1_readdata;
	io_dev_t    dev_sel;
	byte_bank_t byte_readdata;
	logic [7:0] syscfg;

	logic [7:0] syscfg_model = 8'hA2; // Expected syscfg.
	logic       boot_flag = 1'b1;
	integer     seed = 32'hf657481a;
	int         errors = 0;
	int         tests = 0;
	int         transfers = 0;
	int         cycles = 0;
	io_addr_t   beat_addr_q[$];
	io_len_t    beat_size_q[$];
	io_data_t   beat_wdata_q[$];
	logic [1:0] beat_dir_q[$];

	io_system dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	always_comb begin
		for (int i = 0; i < $bits(byte_bank_t) / 8; i++)
			byte_readdata[i] = bus_address[7:0] ^ 8'(i + int'(DEV_FLOPPY)); // Port XOR code.
	end
	assign hdd0_readdata = {bus_address, bus_address};
	assign hdd1_readdata = ~{bus_address, bus_address};

	always @(posedge clk_sys) begin
		if (bus_read || bus_write) begin
			beat_addr_q.push_back(bus_address);
			beat_size_q.push_back(bus_datasize);
			beat_wdata_q.push_back(bus_writedata);
			beat_dir_q.push_back({bus_read, bus_write});
		end
	end

	initial begin
		while (cycles < TIMEOUT) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout after %0d cycles with the CPU handshake still running", cycles);
		$display("*** FAILED ***");
		$finish;
	end

	task automatic note_error(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic check_data(input io_data_t got, input io_data_t exp, input string what);
		if (got !== exp)
			note_error($sformatf("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_dev(input io_dev_t got, input io_dev_t exp, input string what);
		if (got !== exp)
			note_error($sformatf("Mismatch at %0t: %s got %s, expected %s", $time, what,
				got.name(), exp.name()));
	endtask

	task automatic check_syscfg(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			note_error($sformatf("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_beat(input io_addr_t got_a, input io_addr_t exp_a, input io_len_t got_s,
			input io_len_t exp_s);
		if (got_a !== exp_a || got_s !== exp_s)
			note_error($sformatf("Mismatch at %0t: strobe at %h size %0d, expected %h size %0d",
				$time, got_a, got_s, exp_a, exp_s));
	endtask

	task automatic end_test(input string name, input int mark);
		tests++;
		if (errors == mark)
			$display("Test %0d %s: ok", tests, name);
		else
			$display("Test %0d %s: %0d errors", tests, name, errors - mark);
	endtask

	// Mostly near mapped ranges. Sometimes anywhere.
	function automatic io_addr_t random_port();
		logic [31:0] r;
		r = $random(seed);
		if (r[7:4] == 4'd0)
			return r[31:16];
		return REGION[r[3:0]] + io_addr_t'(r[11:8]);
	endfunction

	function automatic io_dev_t model_dev(input io_addr_t a);
		if (a inside {[16'h01F0:16'h01F7], 16'h03F6}) return DEV_HDD0;
		if (a inside {[16'h0170:16'h0177], 16'h0376}) return DEV_HDD1;
		if (a inside {[16'h03F0:16'h03F7]}) return DEV_FLOPPY;
		if (a inside {[16'h0000:16'h000F], [16'h0080:16'h008F], [16'h00C0:16'h00DF]}) return DEV_DMA;
		if (a inside {[16'h0020:16'h0021], [16'h00A0:16'h00A1]}) return DEV_PIC;
		if (a inside {[16'h0040:16'h0043], 16'h0061}) return DEV_PIT;
		if (a inside {[16'h0060:16'h0067], [16'h0090:16'h009F]}) return DEV_PS2;
		if (a inside {[16'h0070:16'h0071]}) return DEV_RTC;
		if (a inside {[16'h0220:16'h022F], [16'h0388:16'h038B]}) return DEV_SOUND;
		if (a inside {[16'h03F8:16'h03FF], [16'h0330:16'h0331]}) return DEV_UART;
		if (a inside {[16'h03B0:16'h03DF]}) return DEV_VGA;
		if (a == 16'h0201) return DEV_JOY;
		if (a == 16'h8888) return DEV_SYSCTL;
		return DEV_NONE;
	endfunction

	function automatic logic [7:0] model_byte(input io_addr_t a);
		case (model_dev(a))
			DEV_HDD0:             return a[7:0];
			DEV_HDD1:             return ~a[7:0];
			DEV_NONE, DEV_SYSCTL: return 8'hFF;
			default:              return a[7:0] ^ 8'(model_dev(a));
		endcase
	endfunction

	// One full handshake and the checks on its strobes and results.
	task automatic transfer(input logic wr, input io_addr_t addr, input io_len_t len,
			input io_data_t wd, input int hold);
		io_dev_t  dev;
		logic     wide;
		int       beats;
		io_addr_t a;
		io_data_t rd;
		io_data_t exp_rd;
		dev    = model_dev(addr);
		wide   = (dev inside {DEV_HDD0, DEV_HDD1} && !addr[9]) || dev == DEV_SYSCTL;
		beats  = wide ? 1 : int'(len);
		exp_rd = '0;
		beat_addr_q.delete();
		beat_size_q.delete();
		beat_wdata_q.delete();
		beat_dir_q.delete();
		@(posedge clk_sys);
		cpu_req       <= 1'b1;
		cpu_write     <= wr;
		cpu_address   <= addr;
		cpu_length    <= len;
		cpu_writedata <= wd;
		do @(posedge clk_sys); while (cpu_ack !== 1'b1);
		rd = cpu_readdata;
		repeat (hold) begin
			@(posedge clk_sys);
			if (cpu_ack !== 1'b1 || cpu_readdata !== rd)
				note_error("cpu_ack or cpu_readdata changed while cpu_req was still high");
		end
		cpu_req <= 1'b0;
		do @(posedge clk_sys); while (cpu_ack !== 1'b0);
		if (beat_addr_q.size() != beats)
			note_error($sformatf("Transfer at %h gave %0d strobes instead of %0d", addr,
				beat_addr_q.size(), beats));
		for (int k = 0; k < beats; k++) begin
			a = addr + io_addr_t'(k);
			exp_rd[8*k +: 8] = model_byte(a);
			if (boot_flag && model_dev(a) inside {DEV_HDD0, DEV_HDD1, DEV_FLOPPY}) begin
				syscfg_model = 8'h00;
				boot_flag    = 1'b0;
			end
			if (k < beat_addr_q.size()) begin
				check_beat(beat_addr_q[k], a, beat_size_q[k], wide ? len : 3'd1);
				if (beat_dir_q[k] !== {!wr, wr})
					note_error($sformatf("Strobe at %h went the wrong direction", a));
				if (wr)
					check_data(beat_wdata_q[k], wide ? wd : io_data_t'(wd[8*k +: 8]), "bus_writedata");
			end
		end
		if (wide)
			exp_rd = (dev == DEV_HDD0 ? {addr, addr} : dev == DEV_HDD1 ? ~{addr, addr} : '1) &
				io_data_t'((64'd1 << (8 * len)) - 64'd1);
		if (wr && dev == DEV_SYSCTL && len == 3'd2 && wd[15:8] == 8'hA1) begin
			syscfg_model = wd[7:0];
			boot_flag    = 1'b0;
		end
		check_syscfg(syscfg, syscfg_model, "syscfg");
		check_dev(dev_sel, model_dev(a), "dev_sel");
		if (!wr)
			check_data(rd, exp_rd, $sformatf("cpu_readdata at %h length %0d", addr, len));
		transfers++;
	endtask

	initial begin
		int          mark;
		logic [31:0] r;
		io_addr_t    a;
		reset_cpu     = 1'b1;
		cpu_req       = 1'b0;
		cpu_write     = 1'b0;
		cpu_address   = '0;
		cpu_length    = 3'd1;
		cpu_writedata = '0;
		repeat (3) @(posedge clk_sys);
		reset_cpu <= 1'b0;
		@(posedge clk_sys);

		mark = errors;
		if (cpu_ack !== 1'b0)
			note_error("cpu_ack is high right after reset");
		check_syscfg(syscfg, 8'hA2, "syscfg after reset");
		check_dev(dev_sel, DEV_NONE, "dev_sel after reset");
		r = $random(seed);
		transfer(1'b0, {8'h00, r[7:0]}, io_len_t'(3'd1 << (r[31:8] % 3)), '0, 5);
		end_test("reset and back-pressure", mark);

		mark = errors;
		r = $random(seed);
		a = (r[9:8] == 2'd0) ? 16'h01F0 : (r[9:8] == 2'd1) ? 16'h0170 : 16'h03F0;
		transfer(1'b0, a + io_addr_t'(r[2:0]), io_len_t'(3'd1 << (r[31:16] % 3)), '0, 0);
		check_syscfg(syscfg, 8'h00, "syscfg after first disk access");
		end_test("first disk access", mark);

		mark = errors;
		r = $random(seed);
		transfer(1'b1, 16'h8888, 3'd2, {16'h0000, 8'hA1, r[7:0]}, 0);
		transfer(1'b0, 16'h01F0, 3'd4, '0, 0);
		check_syscfg(syscfg, r[7:0], "syscfg after keyed write and disk access");
		transfer(1'b1, 16'h8888, 3'd2, {r[31:16], 8'hA1 ^ (r[15:8] | 8'h01), ~r[7:0]}, 0);
		transfer(1'b1, 16'h8888, 3'd4, {r[31:16], 8'hA1, ~r[7:0]}, 0);
		transfer(1'b1, 16'h8888, 3'd1, {r[31:16], 8'hA1, ~r[7:0]}, 0);
		check_syscfg(syscfg, r[7:0], "syscfg after rejected writes");
		transfer(1'b1, 16'h8888, 3'd2, {16'h0000, 8'hA1, ~r[7:0]}, 0);
		check_syscfg(syscfg, ~r[7:0], "syscfg after second keyed write");
		end_test("sysctl writes", mark);

		mark = errors;
		for (int i = 0; i < N_READS; i++) begin
			r = $random(seed);
			transfer(1'b0, random_port(), io_len_t'(3'd1 << (r % 3)), '0, 0);
		end
		end_test("random reads", mark);

		mark = errors;
		for (int i = 0; i < N_SPLIT; i++) begin
			r = $random(seed);
			a = r[4] ? random_port() : ((r[5] ? 16'h01F0 : 16'h0170) + io_addr_t'(r[2:0]));
			transfer(r[6], a, r[7] ? 3'd2 : 3'd4, $random(seed), 0);
		end
		end_test("beat splitting", mark);

		$display("Summary: %0d tests, %0d transfers, %0d errors", tests, transfers, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/io_pkg.sv
hdl/io_decode.sv
hdl/io_bridge.sv
hdl/sysctl_port.sv
hdl/io_system.sv
sim/tb_io_system.sv
